//--- source/mdu_pkg.sv
`default_nettype none

package mdu_pkg;

    // Datapath widths
    localparam int WORD_W    = 32;
    localparam int DWORD_W   = 2 * WORD_W;
    localparam int SLICE_W   = 8;
    localparam int PARTIAL_W = WORD_W + SLICE_W;

    // One lane per multiplier slice
    localparam int NUM_LANES = WORD_W / SLICE_W;

    localparam int OP_W = 4;

    // General-purpose register value, also HI or LO
    typedef logic [WORD_W-1:0] word_t;

    // Combined HI:LO or a full product
    typedef logic [DWORD_W-1:0] dword_t;

    // One multiplier slice
    typedef logic [SLICE_W-1:0] slice_t;

    // Magnitude times one slice
    typedef logic [PARTIAL_W-1:0] partial_t;

    typedef enum logic [OP_W-1:0] {
        OP_NOP   = 4'd0,
        OP_MULT  = 4'd1,
        OP_MULTU = 4'd2,
        OP_MADD  = 4'd3,
        OP_MADDU = 4'd4,
        OP_MSUB  = 4'd5,
        OP_MSUBU = 4'd6,
        OP_MTHI  = 4'd7,
        OP_MTLO  = 4'd8
    } mdu_op_t;

    localparam word_t HILO_RESET = '0;

endpackage

`default_nettype wire

//--- source/mul_operand_prep.sv
`default_nettype none

module mul_operand_prep (
    input  wire                 i_clk,
    input  wire                 i_rst_n,

    input  wire                 i_valid,
    input  mdu_pkg::mdu_op_t    i_op,
    input  mdu_pkg::word_t      i_opr1,
    input  mdu_pkg::word_t      i_opr2,

    output mdu_pkg::word_t      o_mcand,
    output mdu_pkg::slice_t     o_slice [mdu_pkg::NUM_LANES],

    output logic                o_tag_valid,
    output mdu_pkg::mdu_op_t    o_tag_op,
    output mdu_pkg::word_t      o_tag_word,
    output logic                o_tag_negate
);

    import mdu_pkg::*;

    logic    is_signed;
    logic    opr1_neg;
    logic    opr2_neg;
    logic    negate;
    word_t   opr1_mag;
    word_t   opr2_mag;

    // First tag stage lines up with the lane inputs
    logic    tag1_valid;
    mdu_op_t tag1_op;
    word_t   tag1_word;
    logic    tag1_negate;

    always_comb begin
        case (i_op)
            OP_MULT,
            OP_MADD,
            OP_MSUB: is_signed = 1'b1;
            default: is_signed = 1'b0;
        endcase
    end

    assign opr1_neg = is_signed & i_opr1[WORD_W-1];
    assign opr2_neg = is_signed & i_opr2[WORD_W-1];

    // Most negative value maps onto itself, which is its correct magnitude
    assign opr1_mag = opr1_neg ? word_t'(-i_opr1) : i_opr1;
    assign opr2_mag = opr2_neg ? word_t'(-i_opr2) : i_opr2;

    assign negate = opr1_neg ^ opr2_neg;

    // Lane operands
    always_ff @(posedge i_clk) begin
        o_mcand <= opr1_mag;
        for (int k = 0; k < NUM_LANES; k++) begin
            o_slice[k] <= opr2_mag[k*SLICE_W +: SLICE_W];
        end
    end

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            tag1_valid  <= 1'b0;
            o_tag_valid <= 1'b0;
        end else begin
            tag1_valid  <= i_valid;
            o_tag_valid <= tag1_valid;
        end
    end

    always_ff @(posedge i_clk) begin
        tag1_op      <= i_op;
        tag1_word    <= i_opr1;
        tag1_negate  <= negate;

        o_tag_op     <= tag1_op;
        o_tag_word   <= tag1_word;
        o_tag_negate <= tag1_negate;
    end

endmodule

`default_nettype wire

//--- source/mul_partial_lane.sv
`default_nettype none

module mul_partial_lane (
    input  wire                 i_clk,
    input  wire                 i_rst_n,

    input  mdu_pkg::word_t      i_mcand,
    input  mdu_pkg::slice_t     i_slice,

    output mdu_pkg::partial_t   o_partial
);

    import mdu_pkg::*;

    partial_t product;

    // 32x8 unsigned product fits in 40 bits
    assign product = partial_t'(i_mcand) * partial_t'(i_slice);

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            o_partial <= '0;
        end else begin
            o_partial <= product;
        end
    end

endmodule

`default_nettype wire

//--- source/hilo_accum.sv
`default_nettype none

module hilo_accum (
    input  wire                 i_clk,
    input  wire                 i_rst_n,

    input  mdu_pkg::partial_t   i_partial [mdu_pkg::NUM_LANES],

    input  wire                 i_tag_valid,
    input  mdu_pkg::mdu_op_t    i_tag_op,
    input  mdu_pkg::word_t      i_tag_word,
    input  wire                 i_tag_negate,

    output mdu_pkg::word_t      o_hi,
    output mdu_pkg::word_t      o_lo,
    output logic                o_done
);

    import mdu_pkg::*;

    dword_t product_mag;
    dword_t product;
    dword_t hilo;
    dword_t hilo_next;
    logic   hilo_we;

    // Lane k carries multiplier bits 8k and up
    always_comb begin
        product_mag = '0;
        for (int k = 0; k < NUM_LANES; k++) begin
            product_mag = product_mag + (dword_t'(i_partial[k]) << (k * SLICE_W));
        end
    end

    assign product = i_tag_negate ? dword_t'(-product_mag) : product_mag;

    assign hilo = {o_hi, o_lo};

    always_comb begin
        hilo_next = hilo;
        hilo_we   = i_tag_valid;
        case (i_tag_op)
            OP_MULT,
            OP_MULTU: hilo_next = product;
            OP_MADD,
            OP_MADDU: hilo_next = hilo + product;
            OP_MSUB,
            OP_MSUBU: hilo_next = hilo - product;
            OP_MTHI:  hilo_next = {i_tag_word, o_lo};
            OP_MTLO:  hilo_next = {o_hi, i_tag_word};
            default:  hilo_we   = 1'b0;
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            o_hi <= HILO_RESET;
            o_lo <= HILO_RESET;
        end else if (hilo_we) begin
            o_hi <= hilo_next[DWORD_W-1:WORD_W];
            o_lo <= hilo_next[WORD_W-1:0];
        end
    end

    // NOP retires too
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            o_done <= 1'b0;
        end else begin
            o_done <= i_tag_valid;
        end
    end

endmodule

`default_nettype wire

//--- source/hilo_mul_unit.sv
`default_nettype none

module hilo_mul_unit (
    input  wire                 i_clk,
    input  wire                 i_rst_n,

    input  wire                 i_valid,
    input  mdu_pkg::mdu_op_t    i_op,
    input  mdu_pkg::word_t      i_opr1,
    input  mdu_pkg::word_t      i_opr2,

    output mdu_pkg::word_t      o_hi,
    output mdu_pkg::word_t      o_lo,
    output wire                 o_done
);

    import mdu_pkg::*;

    word_t    p_mcand;
    slice_t   p_slice [NUM_LANES];

    logic     t_valid;
    mdu_op_t  t_op;
    word_t    t_word;
    logic     t_negate;

    partial_t lane_partial [NUM_LANES];

    mul_operand_prep prep0 (
        .i_clk          (i_clk),
        .i_rst_n        (i_rst_n),

        .i_valid        (i_valid),
        .i_op           (i_op),
        .i_opr1         (i_opr1),
        .i_opr2         (i_opr2),

        .o_mcand        (p_mcand),
        .o_slice        (p_slice),

        .o_tag_valid    (t_valid),
        .o_tag_op       (t_op),
        .o_tag_word     (t_word),
        .o_tag_negate   (t_negate)
    );

    // One lane per multiplier slice
    for (genvar k = 0; k < NUM_LANES; k++) begin : g_lane
        mul_partial_lane lane (
            .i_clk      (i_clk),
            .i_rst_n    (i_rst_n),

            .i_mcand    (p_mcand),
            .i_slice    (p_slice[k]),

            .o_partial  (lane_partial[k])
        );
    end

    hilo_accum accum0 (
        .i_clk          (i_clk),
        .i_rst_n        (i_rst_n),

        .i_partial      (lane_partial),

        .i_tag_valid    (t_valid),
        .i_tag_op       (t_op),
        .i_tag_word     (t_word),
        .i_tag_negate   (t_negate),

        .o_hi           (o_hi),
        .o_lo           (o_lo),
        .o_done         (o_done)
    );

endmodule

`default_nettype wire

//--- test/hilo_checker.sv
`default_nettype none

module hilo_checker (
    input  wire                 i_clk,
    input  wire                 i_rst_n,

    input  wire                 i_valid,
    input  mdu_pkg::mdu_op_t    i_op,
    input  mdu_pkg::word_t      i_opr1,
    input  mdu_pkg::word_t      i_opr2,

    input  mdu_pkg::word_t      i_hi,
    input  mdu_pkg::word_t      i_lo,
    input  wire                 i_done,

    output int                  o_pending,
    output int                  o_errors,
    output int                  o_pass_count,
    output int                  o_fail_count
);

    import mdu_pkg::*;

    // Issue edge to the edge where o_done is first seen high
    localparam int LATENCY = 3;

    logic [OP_W-1:0] q_op [$];
    word_t           q_a [$];
    word_t           q_b [$];
    int              q_cycle [$];

    dword_t model;
    int     cycle;
    int     issued;
    int     retired;
    int     test_err_start;

    // HI:LO after one operation as the instruction definitions give it
    function automatic dword_t apply_op(input dword_t hilo, input mdu_op_t op,
                                        input word_t a, input word_t b);
        dword_t sa;
        dword_t sb;
        dword_t prod_s;
        dword_t prod_u;
        dword_t result;
        sa     = {{WORD_W{a[WORD_W-1]}}, a};
        sb     = {{WORD_W{b[WORD_W-1]}}, b};
        prod_s = sa * sb;
        prod_u = {{WORD_W{1'b0}}, a} * {{WORD_W{1'b0}}, b};
        case (op)
            OP_MULT:  result = prod_s;
            OP_MULTU: result = prod_u;
            OP_MADD:  result = hilo + prod_s;
            OP_MADDU: result = hilo + prod_u;
            OP_MSUB:  result = hilo - prod_s;
            OP_MSUBU: result = hilo - prod_u;
            OP_MTHI:  result = {a, hilo[WORD_W-1:0]};
            OP_MTLO:  result = {hilo[DWORD_W-1:WORD_W], a};
            default:  result = hilo;
        endcase
        return result;
    endfunction

    task automatic compare_word(input string name, input word_t exp, input word_t act,
                                input string when);
        if (act !== exp) begin
            $display("FAIL %s expected 0x%08h got 0x%08h %s at cycle %0d",
                     name, exp, act, when, cycle);
            o_errors++;
        end
    endtask

    initial begin
        model          = {HILO_RESET, HILO_RESET};
        cycle          = 0;
        issued         = 0;
        retired        = 0;
        test_err_start = 0;
        o_pending      = 0;
        o_errors       = 0;
        o_pass_count   = 0;
        o_fail_count   = 0;
    end

    always @(posedge i_clk) begin : monitor
        logic [OP_W-1:0] op;
        word_t           a;
        word_t           b;
        int              issue_cycle;
        if (!i_rst_n) begin
            // Anything in flight is discarded by reset
            q_op.delete();
            q_a.delete();
            q_b.delete();
            q_cycle.delete();
            model     = {HILO_RESET, HILO_RESET};
            o_pending = 0;
        end else begin
            if (i_done) begin
                if (q_op.size() == 0) begin
                    $display("Error: o_done pulsed at cycle %0d with no operation in flight",
                             cycle);
                    o_errors++;
                end else begin
                    op          = q_op.pop_front();
                    a           = q_a.pop_front();
                    b           = q_b.pop_front();
                    issue_cycle = q_cycle.pop_front();
                    model       = apply_op(model, mdu_op_t'(op), a, b);
                    retired++;
                    if (cycle - issue_cycle != LATENCY) begin
                        $display("Error: operation from cycle %0d took %0d cycles instead of %0d",
                                 issue_cycle, cycle - issue_cycle, LATENCY);
                        o_errors++;
                    end
                    compare_word("o_hi", model[DWORD_W-1:WORD_W], i_hi, "on retire");
                    compare_word("o_lo", model[WORD_W-1:0], i_lo, "on retire");
                end
            end else begin
                // Registers hold between retires
                compare_word("o_hi", model[DWORD_W-1:WORD_W], i_hi, "while idle");
                compare_word("o_lo", model[WORD_W-1:0], i_lo, "while idle");
            end
            if (i_valid) begin
                q_op.push_back(i_op);
                q_a.push_back(i_opr1);
                q_b.push_back(i_opr2);
                q_cycle.push_back(cycle);
                issued++;
            end
            o_pending = q_op.size();
        end
        cycle++;
    end

    task automatic end_test(input string name);
        int n_err;
        if (q_op.size() != 0) begin
            $display("Error: %0d operation(s) still unretired when test %s ended",
                     q_op.size(), name);
            o_errors++;
        end
        n_err = o_errors - test_err_start;
        if (n_err == 0) begin
            $display("[%s] passed, %0d issued, %0d retired", name, issued, retired);
            o_pass_count++;
        end else begin
            $display("[%s] failed with %0d error(s), %0d issued, %0d retired",
                     name, n_err, issued, retired);
            o_fail_count++;
        end
        test_err_start = o_errors;
        issued         = 0;
        retired        = 0;
    endtask

endmodule

`default_nettype wire

//--- test/tb_hilo_mul_unit.sv
`default_nettype none

module tb_hilo_mul_unit;

    import mdu_pkg::*;

    localparam int NUM_CORNERS = 6;
    localparam int NUM_RANDOM  = 400;
    localparam int MAX_IDLE    = 4;
    localparam int DRAIN_MAX   = 8;
    localparam int NUM_TESTS   = 6;

    // Directed tests plus the longest possible random mix and every drain
    localparam int DIRECTED_CYCLES = 2 * NUM_CORNERS * NUM_CORNERS + 64;
    localparam int CYCLE_LIMIT = 2 + DIRECTED_CYCLES + NUM_RANDOM * (1 + MAX_IDLE)
                               + NUM_TESTS * DRAIN_MAX + 50;

    logic    clk;
    logic    rst_n;
    logic    valid;
    mdu_op_t op;
    word_t   opr1;
    word_t   opr2;
    word_t   hi;
    word_t   lo;
    wire     done;

    int          pending;
    int          errors;
    int          pass_count;
    int          fail_count;
    int          cycles;
    logic [31:0] rng;

    hilo_mul_unit dut0 (
        .i_clk   (clk),
        .i_rst_n (rst_n),
        .i_valid (valid),
        .i_op    (op),
        .i_opr1  (opr1),
        .i_opr2  (opr2),
        .o_hi    (hi),
        .o_lo    (lo),
        .o_done  (done)
    );

    hilo_checker chk0 (
        .i_clk        (clk),
        .i_rst_n      (rst_n),
        .i_valid      (valid),
        .i_op         (op),
        .i_opr1       (opr1),
        .i_opr2       (opr2),
        .i_hi         (hi),
        .i_lo         (lo),
        .i_done       (done),
        .o_pending    (pending),
        .o_errors     (errors),
        .o_pass_count (pass_count),
        .o_fail_count (fail_count)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > CYCLE_LIMIT) begin
            $display("Timeout: the run went past %0d cycles without finishing", CYCLE_LIMIT);
            $display("Test FAILED");
            $finish;
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] s;
        s = x;
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    function automatic word_t corner(input int i);
        case (i)
            0:       return 32'h0000_0000;
            1:       return 32'h0000_0001;
            2:       return 32'hffff_ffff;
            3:       return 32'h8000_0000;
            4:       return 32'h7fff_ffff;
            default: return 32'hffff_0003;
        endcase
    endfunction

    // Caller is one time unit past a rising edge
    task automatic issue(input mdu_op_t op_in, input word_t a, input word_t b);
        valid = 1'b1;
        op    = op_in;
        opr1  = a;
        opr2  = b;
        @(posedge clk);
        #1;
    endtask

    task automatic idle(input int n);
        valid = 1'b0;
        op    = OP_NOP;
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic finish_test(input string name);
        int waited;
        valid  = 1'b0;
        op     = OP_NOP;
        waited = 0;
        while (pending != 0 && waited < DRAIN_MAX) begin
            @(posedge clk);
            #1;
            waited++;
        end
        chk0.end_test(name);
    endtask

    initial begin
        logic [3:0] op_sel;
        word_t      a;
        word_t      b;
        cycles = 0;
        rng    = 32'h1572;
        rst_n  = 1'b0;
        valid  = 1'b0;
        op     = OP_NOP;
        opr1   = '0;
        opr2   = '0;
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;

        idle(5);
        finish_test("reset");

        for (int i = 0; i < NUM_CORNERS; i++) begin
            for (int j = 0; j < NUM_CORNERS; j++) begin
                issue(OP_MULT, corner(i), corner(j));
                issue(OP_MULTU, corner(i), corner(j));
            end
        end
        finish_test("products");

        // Unsigned chain wraps past 2^64
        issue(OP_MULTU, 32'hffff_ffff, 32'hffff_ffff);
        issue(OP_MADDU, 32'hffff_ffff, 32'hffff_ffff);
        issue(OP_MADDU, 32'hffff_ffff, 32'hffff_ffff);
        issue(OP_MADDU, 32'hffff_ffff, 32'hffff_ffff);
        issue(OP_MADD, 32'h8000_0000, 32'h7fff_ffff);
        issue(OP_MADD, 32'hffff_ffff, 32'h0000_0001);
        issue(OP_MSUB, 32'h8000_0000, 32'h8000_0000);
        issue(OP_MSUBU, 32'hffff_ffff, 32'h0000_0002);
        issue(OP_MSUBU, 32'h0000_0001, 32'h0000_0001);
        issue(OP_MADD, 32'h7fff_ffff, 32'h7fff_ffff);
        issue(OP_MSUB, 32'hffff_fffe, 32'h0000_0003);
        issue(OP_MADDU, 32'h1234_5678, 32'h9abc_def0);
        finish_test("accumulate");

        issue(OP_MTHI, 32'hdead_beef, 32'h0000_0000);
        issue(OP_MADDU, 32'h0000_0001, 32'h0000_0001);
        issue(OP_MTLO, 32'hffff_ffff, 32'h1111_1111);
        issue(OP_MADD, 32'h0000_0001, 32'h0000_0001);
        idle(2);
        issue(OP_MTLO, 32'h8000_0000, 32'h0000_0000);
        issue(OP_MSUB, 32'hffff_ffff, 32'h0000_0002);
        issue(OP_MTHI, 32'h0000_0000, 32'hffff_ffff);
        issue(OP_MSUBU, 32'h0000_0003, 32'h0000_0005);
        issue(OP_MTHI, 32'h7fff_ffff, 32'h0000_0000);
        issue(OP_MADDU, 32'hffff_ffff, 32'hffff_ffff);
        finish_test("moves");

        // Bursts with and without gaps
        for (int i = 0; i < 8; i++) begin
            rng = xorshift32(rng);
            issue(OP_MULT, rng, ~rng);
        end
        idle(2);
        for (int i = 0; i < 3; i++) begin
            rng = xorshift32(rng);
            issue(OP_MADDU, rng, rng ^ 32'h5a5a_5a5a);
        end
        idle(1);
        for (int i = 0; i < 5; i++) begin
            rng = xorshift32(rng);
            issue(mdu_op_t'(4'(i)), rng, {rng[15:0], rng[31:16]});
        end
        finish_test("latency");

        for (int i = 0; i < NUM_RANDOM; i++) begin
            rng    = xorshift32(rng);
            op_sel = rng % 9;
            rng    = xorshift32(rng);
            a      = (rng[3:0] == 4'd0) ? corner(rng[6:4]) : rng;
            rng    = xorshift32(rng);
            b      = (rng[3:0] == 4'd0) ? corner(rng[6:4]) : rng;
            issue(mdu_op_t'(op_sel), a, b);
            rng = xorshift32(rng);
            if (rng[2:0] == 3'd0) begin
                idle(rng[5:4] + 1);
            end
        end
        finish_test("random");

        $display("Tests passed: %0d, failed: %0d, errors: %0d", pass_count, fail_count, errors);
        if (errors == 0 && fail_count == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- compile.f
source/mdu_pkg.sv
source/mul_operand_prep.sv
source/mul_partial_lane.sv
source/hilo_accum.sv
source/hilo_mul_unit.sv
test/hilo_checker.sv
test/tb_hilo_mul_unit.sv

//--- Bender.yml
package:
  name: hilo_mul_unit

dependencies: {}

sources:
  - source/mdu_pkg.sv
  - source/mul_operand_prep.sv
  - source/mul_partial_lane.sv
  - source/hilo_accum.sv
  - source/hilo_mul_unit.sv
  - target: test
    files:
      - test/hilo_checker.sv
      - test/tb_hilo_mul_unit.sv
